// File: logic/cache_geom_pkg.sv
package cache_geom_pkg;

    // Cache geometry
    localparam int unsigned NUM_SETS   = 16;
    localparam int unsigned NUM_WAYS   = 4;
    localparam int unsigned TAG_WIDTH  = 8;
    localparam int unsigned WORD_WIDTH = 32;
    localparam int unsigned LINE_WORDS = 4;

    // Derived index widths
    localparam int unsigned SET_WIDTH      = $clog2(NUM_SETS);
    localparam int unsigned WORD_IDX_WIDTH = $clog2(LINE_WORDS);

    // One data RAM row per word of every line in every set
    localparam int unsigned DATA_DEPTH = NUM_SETS * LINE_WORDS;

    typedef logic [SET_WIDTH-1:0]      set_t;
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;

    // One bit per way, at most one set
    typedef logic [NUM_WAYS-1:0]       way_vec_t;

    typedef logic [WORD_WIDTH-1:0]     data_word_t;

endpackage

// File: logic/cache_entry_pkg.sv
package cache_entry_pkg;

    import cache_geom_pkg::*;

    // Directory entry as stored in each way's RAM
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    localparam int unsigned BYTES_PER_WORD = WORD_WIDTH / 8;

    // One enable per byte lane of a data word
    typedef logic [BYTES_PER_WORD-1:0] data_be_t;

endpackage

// File: logic/sram_1rw.sv
`timescale 1ns/10ps

module sram_1rw #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DEPTH      = 64
) (
    input  logic                          clk_i,
    input  logic                          cs_i,
    input  logic                          we_i,
    input  logic [(DATA_WIDTH+7)/8-1:0]   be_i,
    input  logic [$clog2(DEPTH)-1:0]      addr_i,
    input  logic [DATA_WIDTH-1:0]         wdata_i,
    output logic [DATA_WIDTH-1:0]         rdata_o
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                // Last lane may be partial when the width is not a byte multiple
                for (int b = 0; b < DATA_WIDTH; b++) begin
                    if (be_i[b/8]) begin
                        mem[addr_i][b] <= wdata_i[b];
                    end
                end
            end else begin
                // Read value stays until the next read
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: logic/dir_init_seq.sv
`timescale 1ns/10ps

module dir_init_seq
    import cache_geom_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    output logic init_busy_o,
    output set_t init_set_o,
    output logic ready_o
);

    set_t set_q;
    logic done_q;

    // One set cleared per cycle until the last one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q  <= '0;
            done_q <= 1'b0;
        end else if (!done_q) begin
            set_q <= set_q + 1'b1;
            if (set_q == set_t'(NUM_SETS - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    assign init_busy_o = ~done_q;
    assign init_set_o  = set_q;
    assign ready_o     = done_q;

endmodule

// File: logic/dir_array.sv
`timescale 1ns/10ps

module dir_array
    import cache_geom_pkg::*;
    import cache_entry_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       init_busy_i,
    input  set_t                       init_set_i,
    input  logic                       lookup_i,
    input  set_t                       lookup_set_i,
    input  tag_t                       lookup_tag_i,
    input  logic                       refill_i,
    input  set_t                       refill_set_i,
    input  way_vec_t                   refill_way_i,
    input  tag_t                       refill_tag_i,
    input  logic                       updt_i,
    input  set_t                       updt_set_i,
    input  way_vec_t                   updt_way_i,
    input  logic                       updt_valid_i,
    input  logic                       updt_dirty_i,
    input  tag_t                       updt_tag_i,
    output way_vec_t                   hit_way_o,
    output dir_entry_t [NUM_WAYS-1:0]  entries_o,
    output set_t                       lookup_set_o
);

    set_t                      dir_addr;
    way_vec_t                  dir_cs;
    way_vec_t                  dir_we;
    dir_entry_t                dir_wentry;
    dir_entry_t [NUM_WAYS-1:0] dir_rentry;
    set_t                      lookup_set_q;
    tag_t                      lookup_tag_q;

    // Sweep has priority, then lookup, refill and update
    always_comb begin
        dir_addr   = '0;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (init_busy_i) begin
            dir_addr = init_set_i;
            dir_cs   = '1;
            dir_we   = '1;
        end else if (lookup_i) begin
            dir_addr = lookup_set_i;
            dir_cs   = '1;
        end else if (refill_i) begin
            dir_addr   = refill_set_i;
            dir_cs     = refill_way_i;
            dir_we     = refill_way_i;
            // Freshly refilled lines start clean
            dir_wentry = '{valid: 1'b1, dirty: 1'b0, tag: refill_tag_i};
        end else if (updt_i) begin
            dir_addr   = updt_set_i;
            dir_cs     = updt_way_i;
            dir_we     = updt_way_i;
            dir_wentry = '{valid: updt_valid_i, dirty: updt_dirty_i, tag: updt_tag_i};
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        sram_1rw #(
            .DATA_WIDTH ($bits(dir_entry_t)),
            .DEPTH      (NUM_SETS)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .be_i    ('1),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign hit_way_o[w] = dir_rentry[w].valid && (dir_rentry[w].tag == lookup_tag_q);
    end

    // Keep the looked-up set and tag alongside the held RAM output
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_set_q <= lookup_set_i;
            lookup_tag_q <= lookup_tag_i;
        end
    end

    assign entries_o    = dir_rentry;
    assign lookup_set_o = lookup_set_q;

    a_dir_strobes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({lookup_i, refill_i, updt_i}));

    // A tag is never refilled into two ways of the same set
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(hit_way_o) |-> $onehot0(hit_way_o));

endmodule

// File: logic/victim_select.sv
`timescale 1ns/10ps

module victim_select
    import cache_geom_pkg::*;
    import cache_entry_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  set_t                       lookup_set_i,
    input  dir_entry_t [NUM_WAYS-1:0]  entries_i,
    input  logic                       refill_i,
    input  set_t                       refill_set_i,
    input  way_vec_t                   refill_way_i,
    output way_vec_t                   victim_way_o,
    output logic                       victim_valid_o,
    output logic                       victim_dirty_o,
    output tag_t                       victim_tag_o
);

    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

    way_idx_t [NUM_SETS-1:0] rr_q;
    logic                    found_invalid;

    function automatic way_idx_t way_to_idx(input way_vec_t way);
        way_idx_t idx;
        idx = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way[w]) begin
                idx = way_idx_t'(w);
            end
        end
        return idx;
    endfunction

    // Pointer moves to the way after the one just refilled
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (refill_i) begin
            rr_q[refill_set_i] <= way_to_idx(refill_way_i) + 1'b1;
        end
    end

    always_comb begin
        victim_way_o  = '0;
        found_invalid = 1'b0;
        // Lowest invalid way first
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!entries_i[w].valid && !found_invalid) begin
                victim_way_o[w] = 1'b1;
                found_invalid   = 1'b1;
            end
        end
        if (!found_invalid) begin
            victim_way_o = way_vec_t'(1) << rr_q[lookup_set_i];
        end

        victim_valid_o = 1'b0;
        victim_dirty_o = 1'b0;
        victim_tag_o   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            victim_valid_o |= victim_way_o[w] & entries_i[w].valid;
            victim_dirty_o |= victim_way_o[w] & entries_i[w].dirty;
            victim_tag_o   |= {TAG_WIDTH{victim_way_o[w]}} & entries_i[w].tag;
        end
    end

    // Pointer update needs exactly one refilled way
    a_refill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_i |-> $onehot(refill_way_i));

endmodule

// File: logic/data_array.sv
`timescale 1ns/10ps

module data_array
    import cache_geom_pkg::*;
    import cache_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  way_vec_t   hit_way_i,
    input  logic       read_i,
    input  set_t       read_set_i,
    input  word_idx_t  read_word_i,
    input  logic       write_i,
    input  set_t       write_set_i,
    input  word_idx_t  write_word_i,
    input  data_word_t write_data_i,
    input  data_be_t   write_be_i,
    input  logic       refill_i,
    input  set_t       refill_set_i,
    input  way_vec_t   refill_way_i,
    input  word_idx_t  refill_word_i,
    input  data_word_t refill_data_i,
    output data_word_t read_data_o
);

    logic [$clog2(DATA_DEPTH)-1:0] ram_addr;
    way_vec_t                      ram_cs;
    way_vec_t                      ram_we;
    data_be_t                      ram_be;
    data_word_t                    ram_wdata;
    data_word_t [NUM_WAYS-1:0]     ram_rdata;

    // Row address is set * LINE_WORDS + word, a plain concatenation here
    always_comb begin
        ram_addr  = '0;
        ram_cs    = '0;
        ram_we    = '0;
        ram_be    = '0;
        ram_wdata = '0;
        if (refill_i) begin
            ram_addr  = {refill_set_i, refill_word_i};
            ram_cs    = refill_way_i;
            ram_we    = refill_way_i;
            ram_be    = '1;
            ram_wdata = refill_data_i;
        end else if (write_i) begin
            ram_addr  = {write_set_i, write_word_i};
            ram_cs    = hit_way_i;
            ram_we    = hit_way_i;
            ram_be    = write_be_i;
            ram_wdata = write_data_i;
        end else if (read_i) begin
            // Read all ways, the hit way is picked next cycle
            ram_addr = {read_set_i, read_word_i};
            ram_cs   = '1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        sram_1rw #(
            .DATA_WIDTH (WORD_WIDTH),
            .DEPTH      (DATA_DEPTH)
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (ram_cs[w]),
            .we_i    (ram_we[w]),
            .be_i    (ram_be),
            .addr_i  (ram_addr),
            .wdata_i (ram_wdata),
            .rdata_o (ram_rdata[w])
        );
    end

    // Hit way from the lookup that returns in the same cycle
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            read_data_o |= {WORD_WIDTH{hit_way_i[w]}} & ram_rdata[w];
        end
    end

    a_data_strobes: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({read_i, write_i, refill_i}));

endmodule

// File: logic/cache_memctrl.sv
`timescale 1ns/10ps

module cache_memctrl
    import cache_geom_pkg::*;
    import cache_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    output logic       ready_o,
    input  logic       dir_lookup_i,
    input  set_t       dir_lookup_set_i,
    input  tag_t       dir_lookup_tag_i,
    input  logic       dir_refill_i,
    input  set_t       dir_refill_set_i,
    input  way_vec_t   dir_refill_way_i,
    input  tag_t       dir_refill_tag_i,
    input  logic       dir_updt_i,
    input  set_t       dir_updt_set_i,
    input  way_vec_t   dir_updt_way_i,
    input  logic       dir_updt_valid_i,
    input  logic       dir_updt_dirty_i,
    input  tag_t       dir_updt_tag_i,
    output way_vec_t   dir_hit_way_o,
    output way_vec_t   dir_victim_way_o,
    output logic       dir_victim_valid_o,
    output logic       dir_victim_dirty_o,
    output tag_t       dir_victim_tag_o,
    input  logic       data_read_i,
    input  set_t       data_read_set_i,
    input  word_idx_t  data_read_word_i,
    input  logic       data_write_i,
    input  set_t       data_write_set_i,
    input  word_idx_t  data_write_word_i,
    input  data_word_t data_write_data_i,
    input  data_be_t   data_write_be_i,
    input  logic       data_refill_i,
    input  set_t       data_refill_set_i,
    input  way_vec_t   data_refill_way_i,
    input  word_idx_t  data_refill_word_i,
    input  data_word_t data_refill_data_i,
    output data_word_t data_read_data_o
);

    logic                      init_busy;
    set_t                      init_set;
    dir_entry_t [NUM_WAYS-1:0] dir_entries;
    set_t                      dir_lookup_set_q;

    dir_init_seq u_init (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .init_busy_o (init_busy),
        .init_set_o  (init_set),
        .ready_o     (ready_o)
    );

    dir_array u_dir (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .init_busy_i  (init_busy),
        .init_set_i   (init_set),
        .lookup_i     (dir_lookup_i),
        .lookup_set_i (dir_lookup_set_i),
        .lookup_tag_i (dir_lookup_tag_i),
        .refill_i     (dir_refill_i),
        .refill_set_i (dir_refill_set_i),
        .refill_way_i (dir_refill_way_i),
        .refill_tag_i (dir_refill_tag_i),
        .updt_i       (dir_updt_i),
        .updt_set_i   (dir_updt_set_i),
        .updt_way_i   (dir_updt_way_i),
        .updt_valid_i (dir_updt_valid_i),
        .updt_dirty_i (dir_updt_dirty_i),
        .updt_tag_i   (dir_updt_tag_i),
        .hit_way_o    (dir_hit_way_o),
        .entries_o    (dir_entries),
        .lookup_set_o (dir_lookup_set_q)
    );

    victim_select u_victim (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_set_i   (dir_lookup_set_q),
        .entries_i      (dir_entries),
        .refill_i       (dir_refill_i),
        .refill_set_i   (dir_refill_set_i),
        .refill_way_i   (dir_refill_way_i),
        .victim_way_o   (dir_victim_way_o),
        .victim_valid_o (dir_victim_valid_o),
        .victim_dirty_o (dir_victim_dirty_o),
        .victim_tag_o   (dir_victim_tag_o)
    );

    data_array u_data (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .hit_way_i     (dir_hit_way_o),
        .read_i        (data_read_i),
        .read_set_i    (data_read_set_i),
        .read_word_i   (data_read_word_i),
        .write_i       (data_write_i),
        .write_set_i   (data_write_set_i),
        .write_word_i  (data_write_word_i),
        .write_data_i  (data_write_data_i),
        .write_be_i    (data_write_be_i),
        .refill_i      (data_refill_i),
        .refill_set_i  (data_refill_set_i),
        .refill_way_i  (data_refill_way_i),
        .refill_word_i (data_refill_word_i),
        .refill_data_i (data_refill_data_i),
        .read_data_o   (data_read_data_o)
    );

endmodule

// File: testbench/memctrl_checker.sv
`timescale 1ns/10ps

module memctrl_checker
    import cache_geom_pkg::*;
(
    input  logic       clk_i,
    input  way_vec_t   hit_way_i,
    input  way_vec_t   victim_way_i,
    input  logic       victim_valid_i,
    input  logic       victim_dirty_i,
    input  tag_t       victim_tag_i,
    input  data_word_t read_data_i,
    input  logic       chk_dir_i,
    input  logic       chk_read_i,
    input  way_vec_t   exp_hit_way_i,
    input  way_vec_t   exp_victim_way_i,
    input  logic       exp_victim_valid_i,
    input  logic       exp_victim_dirty_i,
    input  tag_t       exp_victim_tag_i,
    input  data_word_t exp_read_data_i,
    input  logic       test_done_i,
    input  logic [2:0] test_id_i,
    output int         check_count_o,
    output int         error_count_o
);

    // Expectations of the request cycle, compared one cycle later
    logic       chk_dir_q = 1'b0;
    logic       chk_read_q = 1'b0;
    way_vec_t   exp_hit_way_q;
    way_vec_t   exp_victim_way_q;
    logic       exp_victim_valid_q;
    logic       exp_victim_dirty_q;
    tag_t       exp_victim_tag_q;
    data_word_t exp_read_data_q;
    int         checks = 0;
    int         errors = 0;
    int         checks_base = 0;
    int         errors_base = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    always @(posedge clk_i) begin
        chk_dir_q          <= chk_dir_i;
        chk_read_q         <= chk_read_i;
        exp_hit_way_q      <= exp_hit_way_i;
        exp_victim_way_q   <= exp_victim_way_i;
        exp_victim_valid_q <= exp_victim_valid_i;
        exp_victim_dirty_q <= exp_victim_dirty_i;
        exp_victim_tag_q   <= exp_victim_tag_i;
        exp_read_data_q    <= exp_read_data_i;
        if (test_done_i) begin
            $display("Test %0d finished: %0d checks, %0d mismatches",
                     test_id_i, checks - checks_base, errors - errors_base);
            checks_base = checks;
            errors_base = errors;
        end
    end

    // Mid-cycle, the DUT outputs have settled since the rising edge
    always @(negedge clk_i) begin
        if (chk_dir_q) begin
            check_value("dir_hit_way_o", hit_way_i, exp_hit_way_q);
            check_value("dir_victim_way_o", victim_way_i, exp_victim_way_q);
            check_value("dir_victim_valid_o", victim_valid_i, exp_victim_valid_q);
            check_value("dir_victim_dirty_o", victim_dirty_i, exp_victim_dirty_q);
            check_value("dir_victim_tag_o", victim_tag_i, exp_victim_tag_q);
        end
        if (chk_read_q) begin
            check_value("data_read_data_o", read_data_i, exp_read_data_q);
        end
    end

    assign check_count_o = checks;
    assign error_count_o = errors;

endmodule

// File: testbench/tb_cache_memctrl.sv
`timescale 1ns/10ps

module tb_cache_memctrl
    import cache_geom_pkg::*;
    import cache_entry_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam logic [31:0] SEED = 32'd64;
    localparam int T1_LOOKUPS = 16;
    localparam int T2_REFILLS = 24;
    localparam int T3_ROUNDS  = 6;
    localparam int T4_LINES   = 8;
    localparam int T6_SETS    = 4;
    // Upper bound on driven cycles over reset, sweep and all tests
    localparam int OPS_BUDGET = 8 + NUM_SETS + T1_LOOKUPS + 2 * T2_REFILLS
                              + 3 * NUM_WAYS + 3 * T3_ROUNDS + 9 * T4_LINES
                              + 3 * NUM_SETS + 8 * T6_SETS + 12;
    localparam int TIMEOUT_NS = OPS_BUDGET * CLK_PERIOD * 4;

    logic       clk;
    logic       rst_n;
    logic       ready;
    logic       dir_lookup, dir_refill, dir_updt;
    set_t       dir_lookup_set, dir_refill_set, dir_updt_set;
    tag_t       dir_lookup_tag, dir_refill_tag, dir_updt_tag;
    way_vec_t   dir_refill_way, dir_updt_way;
    logic       dir_updt_valid, dir_updt_dirty;
    way_vec_t   dir_hit_way, dir_victim_way;
    logic       dir_victim_valid, dir_victim_dirty;
    tag_t       dir_victim_tag;
    logic       data_read, data_write, data_refill;
    set_t       data_read_set, data_write_set, data_refill_set;
    word_idx_t  data_read_word, data_write_word, data_refill_word;
    data_word_t data_write_data, data_refill_data, data_read_data;
    data_be_t   data_write_be;
    way_vec_t   data_refill_way;

    // Expectations handed to the checker
    logic       chk_dir, chk_read;
    way_vec_t   exp_hit_way, exp_victim_way;
    logic       exp_victim_valid, exp_victim_dirty;
    tag_t       exp_victim_tag;
    data_word_t exp_read_data;
    logic       test_done;
    logic [2:0] test_id;
    int         check_count, error_count;

    // Reference model of directory, pointers and data
    logic       m_valid [NUM_SETS][NUM_WAYS];
    logic       m_dirty [NUM_SETS][NUM_WAYS];
    tag_t       m_tag   [NUM_SETS][NUM_WAYS];
    logic       m_known [NUM_SETS][NUM_WAYS];
    data_word_t m_data  [NUM_SETS][NUM_WAYS][LINE_WORDS];
    int         m_rr    [NUM_SETS];
    int         last_hit;
    logic [31:0] rng_state;
    int         setup_errors;
    int         cycles;

    cache_memctrl DUT (
        .clk_i (clk), .rst_ni (rst_n), .ready_o (ready),
        .dir_lookup_i (dir_lookup), .dir_lookup_set_i (dir_lookup_set),
        .dir_lookup_tag_i (dir_lookup_tag),
        .dir_refill_i (dir_refill), .dir_refill_set_i (dir_refill_set),
        .dir_refill_way_i (dir_refill_way), .dir_refill_tag_i (dir_refill_tag),
        .dir_updt_i (dir_updt), .dir_updt_set_i (dir_updt_set),
        .dir_updt_way_i (dir_updt_way), .dir_updt_valid_i (dir_updt_valid),
        .dir_updt_dirty_i (dir_updt_dirty), .dir_updt_tag_i (dir_updt_tag),
        .dir_hit_way_o (dir_hit_way), .dir_victim_way_o (dir_victim_way),
        .dir_victim_valid_o (dir_victim_valid), .dir_victim_dirty_o (dir_victim_dirty),
        .dir_victim_tag_o (dir_victim_tag),
        .data_read_i (data_read), .data_read_set_i (data_read_set),
        .data_read_word_i (data_read_word),
        .data_write_i (data_write), .data_write_set_i (data_write_set),
        .data_write_word_i (data_write_word), .data_write_data_i (data_write_data),
        .data_write_be_i (data_write_be),
        .data_refill_i (data_refill), .data_refill_set_i (data_refill_set),
        .data_refill_way_i (data_refill_way), .data_refill_word_i (data_refill_word),
        .data_refill_data_i (data_refill_data), .data_read_data_o (data_read_data)
    );

    memctrl_checker u_checker (
        .clk_i (clk), .hit_way_i (dir_hit_way), .victim_way_i (dir_victim_way),
        .victim_valid_i (dir_victim_valid), .victim_dirty_i (dir_victim_dirty),
        .victim_tag_i (dir_victim_tag), .read_data_i (data_read_data),
        .chk_dir_i (chk_dir), .chk_read_i (chk_read),
        .exp_hit_way_i (exp_hit_way), .exp_victim_way_i (exp_victim_way),
        .exp_victim_valid_i (exp_victim_valid), .exp_victim_dirty_i (exp_victim_dirty),
        .exp_victim_tag_i (exp_victim_tag), .exp_read_data_i (exp_read_data),
        .test_done_i (test_done), .test_id_i (test_id),
        .check_count_o (check_count), .error_count_o (error_count)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic int find_hit(input set_t s, input tag_t t);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Lowest invalid way, else the set's round-robin pointer
    function automatic int pick_victim(input set_t s);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!m_valid[s][w]) begin
                return w;
            end
        end
        return m_rr[s];
    endfunction

    function automatic tag_t unique_tag(input set_t s);
        tag_t t;
        t = tag_t'(next_rand());
        while (find_hit(s, t) >= 0) begin
            t = tag_t'(next_rand());
        end
        return t;
    endfunction

    function automatic int known_way(input set_t s);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_known[s][w]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic clear_strobes();
        dir_lookup  = 1'b0;
        dir_refill  = 1'b0;
        dir_updt    = 1'b0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        data_refill = 1'b0;
        chk_dir     = 1'b0;
        chk_read    = 1'b0;
        test_done   = 1'b0;
    endtask

    task automatic init_inputs();
        clear_strobes();
        {dir_lookup_set, dir_lookup_tag, dir_refill_set, dir_refill_way} = '0;
        {dir_refill_tag, dir_updt_set, dir_updt_way, dir_updt_tag} = '0;
        {dir_updt_valid, dir_updt_dirty} = '0;
        {data_read_set, data_read_word, data_write_set, data_write_word} = '0;
        {data_write_data, data_write_be, data_refill_set, data_refill_way} = '0;
        {data_refill_word, data_refill_data} = '0;
        {exp_hit_way, exp_victim_way, exp_victim_valid, exp_victim_dirty} = '0;
        {exp_victim_tag, exp_read_data, test_id} = '0;
    endtask

    task automatic lookup(input set_t s, input tag_t t, input logic do_read,
                          input word_idx_t word);
        int hit;
        int vic;
        @(negedge clk);
        clear_strobes();
        hit = find_hit(s, t);
        vic = pick_victim(s);
        dir_lookup       = 1'b1;
        dir_lookup_set   = s;
        dir_lookup_tag   = t;
        exp_hit_way      = (hit >= 0) ? way_vec_t'(1 << hit) : '0;
        exp_victim_way   = way_vec_t'(1 << vic);
        exp_victim_valid = m_valid[s][vic];
        exp_victim_dirty = m_dirty[s][vic];
        exp_victim_tag   = m_tag[s][vic];
        chk_dir          = 1'b1;
        if (do_read) begin
            data_read      = 1'b1;
            data_read_set  = s;
            data_read_word = word;
            // A miss selects no way and reads as zero
            exp_read_data  = '0;
            chk_read       = 1'b1;
            if (hit >= 0) begin
                exp_read_data = m_data[s][hit][word];
                chk_read      = m_known[s][hit];
            end
        end
        last_hit = hit;
    endtask

    task automatic dir_refill_way_tag(input set_t s, input int w, input tag_t t);
        @(negedge clk);
        clear_strobes();
        dir_refill     = 1'b1;
        dir_refill_set = s;
        dir_refill_way = way_vec_t'(1 << w);
        dir_refill_tag = t;
        m_valid[s][w]  = 1'b1;
        m_dirty[s][w]  = 1'b0;
        m_tag[s][w]    = t;
        m_known[s][w]  = 1'b0;
        m_rr[s]        = (w + 1) % NUM_WAYS;
    endtask

    task automatic dir_update(input set_t s, input int w, input logic valid,
                              input logic dirty, input tag_t t);
        @(negedge clk);
        clear_strobes();
        dir_updt       = 1'b1;
        dir_updt_set   = s;
        dir_updt_way   = way_vec_t'(1 << w);
        dir_updt_valid = valid;
        dir_updt_dirty = dirty;
        dir_updt_tag   = t;
        m_valid[s][w]  = valid;
        m_dirty[s][w]  = dirty;
        m_tag[s][w]    = t;
    endtask

    task automatic data_refill_line(input set_t s, input int w);
        for (int wd = 0; wd < LINE_WORDS; wd++) begin
            @(negedge clk);
            clear_strobes();
            data_refill      = 1'b1;
            data_refill_set  = s;
            data_refill_way  = way_vec_t'(1 << w);
            data_refill_word = word_idx_t'(wd);
            data_refill_data = next_rand();
            m_data[s][w][wd] = data_refill_data;
        end
        m_known[s][w] = 1'b1;
    endtask

    // Goes to the way that hit in the preceding lookup
    task automatic data_write_word_be(input set_t s, input word_idx_t word,
                                      input data_word_t d, input data_be_t be);
        @(negedge clk);
        clear_strobes();
        data_write      = 1'b1;
        data_write_set  = s;
        data_write_word = word;
        data_write_data = d;
        data_write_be   = be;
        if (last_hit >= 0) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (be[b]) begin
                    m_data[s][last_hit][word][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
    endtask

    task automatic end_test(input logic [2:0] id);
        @(negedge clk);
        clear_strobes();
        test_id   = id;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    task automatic run_tests();
        set_t      s;
        tag_t      t;
        int        v;
        word_idx_t wd;
        // Empty directory after the sweep
        for (int i = 0; i < T1_LOOKUPS; i++) begin
            lookup(set_t'(next_rand()), tag_t'(next_rand()), 1'b0, '0);
        end
        end_test(3'd1);
        // Random refills, then lookups with the same or another tag
        for (int i = 0; i < T2_REFILLS; i++) begin
            s = set_t'(next_rand());
            t = tag_t'(next_rand());
            v = find_hit(s, t);
            if (v < 0) begin
                v = next_rand() % NUM_WAYS;
            end
            dir_refill_way_tag(s, v, t);
            if (next_rand() % 2 == 0) begin
                lookup(s, t, 1'b0, '0);
            end else begin
                lookup(s, tag_t'(next_rand()), 1'b0, '0);
            end
        end
        end_test(3'd2);
        // Invalid ways in ascending order, then round-robin
        s = set_t'(next_rand());
        for (int w = 0; w < NUM_WAYS; w++) begin
            dir_update(s, w, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < NUM_WAYS; i++) begin
            lookup(s, tag_t'(next_rand()), 1'b0, '0);
            dir_refill_way_tag(s, pick_victim(s), unique_tag(s));
        end
        for (int i = 0; i < T3_ROUNDS; i++) begin
            v = pick_victim(s);
            dir_update(s, v, 1'b1, next_rand() % 2 == 1, m_tag[s][v]);
            lookup(s, m_tag[s][v], 1'b0, '0);
            dir_refill_way_tag(s, v, unique_tag(s));
        end
        end_test(3'd3);
        // Whole-line refills read back through hitting lookups
        for (int i = 0; i < T4_LINES; i++) begin
            s = set_t'(next_rand());
            v = pick_victim(s);
            t = unique_tag(s);
            dir_refill_way_tag(s, v, t);
            data_refill_line(s, v);
            for (int w = 0; w < LINE_WORDS; w++) begin
                lookup(s, t, 1'b1, word_idx_t'(w));
            end
        end
        end_test(3'd4);
        // Byte-enabled writes into lines with known data
        for (int i = 0; i < NUM_SETS; i++) begin
            s = set_t'(i);
            v = known_way(s);
            if (v >= 0) begin
                t  = m_tag[s][v];
                wd = word_idx_t'(next_rand());
                lookup(s, t, 1'b0, '0);
                data_write_word_be(s, wd, next_rand(), data_be_t'(next_rand()));
                lookup(s, t, 1'b1, wd);
            end
        end
        end_test(3'd5);
        // Dirty marking and invalidation of the round-robin victim
        for (int i = 0; i < T6_SETS; i++) begin
            s = set_t'(next_rand());
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!m_valid[s][w]) begin
                    dir_refill_way_tag(s, w, unique_tag(s));
                end
            end
            v = pick_victim(s);
            t = m_tag[s][v];
            dir_update(s, v, 1'b1, 1'b1, t);
            lookup(s, t, 1'b0, '0);
            dir_update(s, v, 1'b0, 1'b0, t);
            lookup(s, t, 1'b0, '0);
        end
        end_test(3'd6);
    endtask

    initial begin
        init_inputs();
        rng_state    = SEED;
        last_hit     = -1;
        setup_errors = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_rr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_known[s][w] = 1'b0;
            end
        end
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!ready && cycles < 4 * NUM_SETS) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("ready_o did not rise after the directory sweep");
            setup_errors++;
        end else begin
            if (cycles != NUM_SETS) begin
                $display("MISMATCH at %0d ns: ready_o latency got %0d, expected %0d",
                         $time, cycles, NUM_SETS);
                setup_errors++;
            end
            run_tests();
        end
        repeat (2) @(negedge clk);
        $display("Totals: %0d checks, %0d mismatches, %0d setup errors",
                 check_count, error_count, setup_errors);
        if (error_count == 0 && setup_errors == 0 && check_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run timed out after %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verilog.f
logic/cache_geom_pkg.sv
logic/cache_entry_pkg.sv
logic/sram_1rw.sv
logic/dir_init_seq.sv
logic/dir_array.sv
logic/victim_select.sv
logic/data_array.sv
logic/cache_memctrl.sv
testbench/memctrl_checker.sv
testbench/tb_cache_memctrl.sv
